// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	// ------------------------------------------------------------
	// widths and basic types
	// ------------------------------------------------------------
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 16;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	localparam word_t RESET_PC = 32'h0000_0000;  // first fetch address

	// ------------------------------------------------------------
	// instruction word layout
	// ------------------------------------------------------------
	// opcode [7:0], rt [11:8], ra [15:12], rb [19:16], imm12 [31:20]
	localparam int OPC_LSB = 0;
	localparam int OPC_W   = 8;
	localparam int RT_LSB  = 8;
	localparam int RA_LSB  = 12;
	localparam int RB_LSB  = 16;
	localparam int IMM_LSB = 20;
	localparam int IMM_W   = 12;   // signed

	// opcodes, unknown codes run as nop
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_ADD  = 8'h01,  // rt = ra + rb
		OP_SUB  = 8'h02,  // rt = ra - rb
		OP_AND  = 8'h03,
		OP_OR   = 8'h04,
		OP_XOR  = 8'h05,
		OP_ADDI = 8'h06,  // rt = ra + imm
		OP_LD   = 8'h10,  // rt = mem[ra + imm]
		OP_ST   = 8'h11,  // mem[ra + imm] = rb
		OP_BEQ  = 8'h20,
		OP_BNE  = 8'h21,
		OP_BCS  = 8'h22,
		OP_BCC  = 8'h23,
		OP_BMI  = 8'h24,
		OP_BPL  = 8'h25,
		OP_BRA  = 8'h26,
		OP_HALT = 8'hFF
	} opcode_e;

	// condition flags
	typedef struct packed {
		logic n;  // negative
		logic z;  // zero
		logic c;  // carry, not-borrow on sub
		logic v;  // signed overflow
	} flags_t;

endpackage

// ==== hw/mem_req_if.sv ====
// one word access between control unit and bus master
interface mem_req_if;
	import cpu_pkg::*;

	logic  req;    // held until done
	logic  we;
	word_t adr;
	word_t wdat;
	word_t rdat;   // valid with done on reads
	logic  done;   // single cycle pulse

	modport requester (
		output req,
		output we,
		output adr,
		output wdat,
		input  rdat,
		input  done
	);

	modport responder (
		input  req,
		input  we,
		input  adr,
		input  wdat,
		output rdat,
		output done
	);

endinterface

// ==== hw/alu.sv ====
module alu (
	input  cpu_pkg::opcode_e op_i,
	input  cpu_pkg::word_t   a_i,
	input  cpu_pkg::word_t   b_i,
	input  cpu_pkg::word_t   imm_i,
	input  cpu_pkg::flags_t  flags_i,
	output cpu_pkg::word_t   res_o,
	output cpu_pkg::flags_t  flags_o
);
	import cpu_pkg::*;

	logic          use_imm;
	logic          is_sub;
	word_t         b_sel;
	logic [XLEN:0] sum;
	logic          v_arith;

	// ------------------------------------------------------------
	// adder, shared by add, sub, addi and address calculation
	// ------------------------------------------------------------
	assign use_imm = op_i inside {OP_ADDI, OP_LD, OP_ST};
	assign is_sub  = (op_i == OP_SUB);
	assign b_sel   = use_imm ? imm_i : b_i;

	// a + ~b + 1 for sub, carry out then means no borrow
	assign sum = {1'b0, a_i} + {1'b0, (is_sub ? ~b_sel : b_sel)} + {{XLEN{1'b0}}, is_sub};

	// operand signs agree (add) or differ (sub) and result sign flips from a
	always_comb begin
		if (is_sub)
			v_arith = (a_i[XLEN-1] != b_sel[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
		else
			v_arith = (a_i[XLEN-1] == b_sel[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
	end

	always_comb begin
		res_o = sum[XLEN-1:0];  // arithmetic and load/store address
		case (op_i)
			OP_AND:  res_o = a_i & b_i;
			OP_OR:   res_o = a_i | b_i;
			OP_XOR:  res_o = a_i ^ b_i;
			default: ;
		endcase
	end

	// ------------------------------------------------------------
	// flags
	// ------------------------------------------------------------
	always_comb begin
		flags_o = flags_i;  // loads, stores, branches keep them
		if (op_i inside {OP_ADD, OP_SUB, OP_ADDI}) begin
			flags_o.c = sum[XLEN];
			flags_o.v = v_arith;
		end
		if (op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI}) begin
			flags_o.n = res_o[XLEN-1];
			flags_o.z = (res_o == '0);
		end
	end

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
	input  logic               clk,
	input  logic               rst_i,
	input  cpu_pkg::reg_addr_t ra_i,
	input  cpu_pkg::reg_addr_t rb_i,
	input  cpu_pkg::reg_addr_t rt_i,
	input  logic               wr_en_i,
	input  cpu_pkg::word_t     wr_data_i,
	output cpu_pkg::word_t     ra_val_o,
	output cpu_pkg::word_t     rb_val_o
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en_i && (rt_i != '0)) begin  // r0 ignores writes
			regs[rt_i] <= wr_data_i;
		end
	end

	// combinational reads, r0 is hardwired zero
	assign ra_val_o = (ra_i == '0) ? '0 : regs[ra_i];
	assign rb_val_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

// ==== hw/wb_master.sv ====
module wb_master (
	input  logic            clk,
	input  logic            rst_i,
	mem_req_if.responder    mem,
	output logic            cyc_o,
	output logic            stb_o,
	output logic            we_o,
	output cpu_pkg::word_t  adr_o,
	output cpu_pkg::word_t  dat_o,
	input  cpu_pkg::word_t  dat_i,
	input  logic            ack_i,
	input  logic            rty_i
);

	typedef enum logic [1:0] {WB_IDLE, WB_CYCLE, WB_BACKOFF} wb_state_e;

	wb_state_e state_q;
	logic      start;

	// a request still high in the done cycle is the one just served
	assign start = (state_q == WB_IDLE) && mem.req && !mem.done;

	// ------------------------------------------------------------
	// bus cycle control
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q  <= WB_IDLE;
			cyc_o    <= 1'b0;
			stb_o    <= 1'b0;
			we_o     <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= 1'b0;
			case (state_q)
				WB_IDLE: if (start) begin
					cyc_o   <= 1'b1;
					stb_o   <= 1'b1;
					we_o    <= mem.we;
					state_q <= WB_CYCLE;
				end
				WB_CYCLE: if (ack_i) begin
					cyc_o    <= 1'b0;
					stb_o    <= 1'b0;
					we_o     <= 1'b0;
					mem.done <= 1'b1;
					state_q  <= WB_IDLE;
				end else if (rty_i) begin
					cyc_o   <= 1'b0;  // back off one cycle, we_o held
					stb_o   <= 1'b0;
					state_q <= WB_BACKOFF;
				end
				WB_BACKOFF: begin
					cyc_o   <= 1'b1;  // reissue same access
					stb_o   <= 1'b1;
					state_q <= WB_CYCLE;
				end
				default: state_q <= WB_IDLE;
			endcase
		end
	end

	// address, write data and read data
	always_ff @(posedge clk) begin
		if (start) begin
			adr_o <= mem.adr;
			dat_o <= mem.wdat;
		end
		if (state_q == WB_CYCLE && ack_i)
			mem.rdat <= dat_i;
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		stb_o |-> cyc_o);

	a_adr_hold: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && !ack_i) |=> $stable(adr_o));

endmodule

// ==== hw/cpu_control.sv ====
module cpu_control (
	input  logic                clk,
	input  logic                rst_i,
	mem_req_if.requester        mem,
	output cpu_pkg::reg_addr_t  ra_o,
	output cpu_pkg::reg_addr_t  rb_o,
	output cpu_pkg::reg_addr_t  rt_o,
	input  cpu_pkg::word_t      ra_val_i,
	input  cpu_pkg::word_t      rb_val_i,
	output logic                wr_en_o,
	output cpu_pkg::word_t      wr_data_o,
	output cpu_pkg::opcode_e    op_o,
	output cpu_pkg::word_t      imm_o,
	input  cpu_pkg::word_t      alu_res_i,
	input  cpu_pkg::flags_t     alu_flags_i,
	output cpu_pkg::flags_t     flags_o,
	output logic                halted_o
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_HALT} state_e;

	state_e state_q;
	word_t  pc_q;     // address of next instruction once ir is loaded
	word_t  ir_q;
	word_t  ea_q;     // load/store address
	word_t  sd_q;     // store data
	flags_t flags_q;
	logic   is_alu;
	logic   is_mem;
	logic   take_br;

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------
	assign op_o  = opcode_e'(ir_q[OPC_LSB +: OPC_W]);
	assign rt_o  = ir_q[RT_LSB +: REG_ADDR_W];
	assign ra_o  = ir_q[RA_LSB +: REG_ADDR_W];
	assign rb_o  = ir_q[RB_LSB +: REG_ADDR_W];
	assign imm_o = {{(XLEN-IMM_W){ir_q[IMM_LSB+IMM_W-1]}}, ir_q[IMM_LSB +: IMM_W]};

	assign is_alu = op_o inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
	assign is_mem = op_o inside {OP_LD, OP_ST};

	// branch table
	always_comb begin
		case (op_o)
			OP_BEQ:  take_br = flags_q.z;
			OP_BNE:  take_br = !flags_q.z;
			OP_BCS:  take_br = flags_q.c;
			OP_BCC:  take_br = !flags_q.c;
			OP_BMI:  take_br = flags_q.n;
			OP_BPL:  take_br = !flags_q.n;
			OP_BRA:  take_br = 1'b1;
			default: take_br = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// memory request and write back
	// ------------------------------------------------------------
	assign mem.req  = (state_q == ST_FETCH) || (state_q == ST_MEM);
	assign mem.we   = (state_q == ST_MEM) && (op_o == OP_ST);
	assign mem.adr  = (state_q == ST_MEM) ? ea_q : pc_q;
	assign mem.wdat = sd_q;

	assign wr_en_o = ((state_q == ST_EXEC) && is_alu) ||
		((state_q == ST_MEM) && (op_o == OP_LD) && mem.done);
	assign wr_data_o = (state_q == ST_MEM) ? mem.rdat : alu_res_i;  // load data or alu result

	assign flags_o  = flags_q;
	assign halted_o = (state_q == ST_HALT);

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= ST_FETCH;
			pc_q    <= RESET_PC;
			flags_q <= '0;
		end else begin
			case (state_q)
				ST_FETCH: if (mem.done) begin
					pc_q    <= pc_q + 32'd4;
					state_q <= ST_DECODE;
				end
				ST_DECODE:
					state_q <= (op_o == OP_HALT) ? ST_HALT : ST_EXEC;
				ST_EXEC: begin
					flags_q <= alu_flags_i;  // alu passes them through when untouched
					if (is_mem) begin
						state_q <= ST_MEM;
					end else begin
						if (take_br)
							pc_q <= pc_q + {imm_o[XLEN-3:0], 2'b00};
						state_q <= ST_FETCH;
					end
				end
				ST_MEM: if (mem.done)
					state_q <= ST_FETCH;
				ST_HALT: state_q <= ST_HALT;  // only reset leaves
				default: state_q <= ST_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_FETCH && mem.done)
			ir_q <= mem.rdat;
		if (state_q == ST_DECODE)
			sd_q <= rb_val_i;   // operand read in decode
		if (state_q == ST_EXEC)
			ea_q <= alu_res_i;
	end

	// halt is terminal and quiet on the bus
	a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i)
		halted_o |=> (halted_o && !mem.req));

	// writes to r0 are dropped in reg_file, here only the window is checked
	a_wr_window: assert property (@(posedge clk) disable iff (rst_i)
		!(state_q inside {ST_EXEC, ST_MEM}) |-> !wr_en_o);

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top (
	input  logic           clk,
	input  logic           rst_i,
	output logic           cyc_o,
	output logic           stb_o,
	output logic           we_o,
	output cpu_pkg::word_t adr_o,
	output cpu_pkg::word_t dat_o,
	input  cpu_pkg::word_t dat_i,
	input  logic           ack_i,
	input  logic           rty_i,
	output logic           halted_o
);
	import cpu_pkg::*;

	mem_req_if mem_bus ();

	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rt;
	word_t     ra_val;
	word_t     rb_val;
	logic      wr_en;
	word_t     wr_data;
	opcode_e   op;
	word_t     imm;
	word_t     alu_res;
	flags_t    alu_flags;
	flags_t    flags;

	cpu_control u_ctrl (
		.clk         (clk),
		.rst_i       (rst_i),
		.mem         (mem_bus.requester),
		.ra_o        (ra),
		.rb_o        (rb),
		.rt_o        (rt),
		.ra_val_i    (ra_val),
		.rb_val_i    (rb_val),
		.wr_en_o     (wr_en),
		.wr_data_o   (wr_data),
		.op_o        (op),
		.imm_o       (imm),
		.alu_res_i   (alu_res),
		.alu_flags_i (alu_flags),
		.flags_o     (flags),
		.halted_o    (halted_o)
	);

	reg_file u_regs (
		.clk       (clk),
		.rst_i     (rst_i),
		.ra_i      (ra),
		.rb_i      (rb),
		.rt_i      (rt),
		.wr_en_i   (wr_en),
		.wr_data_i (wr_data),
		.ra_val_o  (ra_val),
		.rb_val_o  (rb_val)
	);

	alu u_alu (
		.op_i    (op),
		.a_i     (ra_val),
		.b_i     (rb_val),
		.imm_i   (imm),
		.flags_i (flags),
		.res_o   (alu_res),
		.flags_o (alu_flags)
	);

	wb_master u_wb (
		.clk   (clk),
		.rst_i (rst_i),
		.mem   (mem_bus.responder),
		.cyc_o (cyc_o),
		.stb_o (stb_o),
		.we_o  (we_o),
		.adr_o (adr_o),
		.dat_o (dat_o),
		.dat_i (dat_i),
		.ack_i (ack_i),
		.rty_i (rty_i)
	);

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// reset released on a rising edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

// ==== bench/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic word_t rand_bits(int n);
	word_t r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
		r = {r[30:0], lfsr_q[0]};
	end
	return r;
endfunction

// assemble one instruction word
function automatic word_t enc(opcode_e op, int rt, int ra, int rb, int imm);
	word_t w;
	w = '0;
	w[OPC_LSB +: OPC_W]     = op;
	w[RT_LSB +: REG_ADDR_W] = rt[REG_ADDR_W-1:0];
	w[RA_LSB +: REG_ADDR_W] = ra[REG_ADDR_W-1:0];
	w[RB_LSB +: REG_ADDR_W] = rb[REG_ADDR_W-1:0];
	w[IMM_LSB +: IMM_W]     = imm[IMM_W-1:0];
	return w;
endfunction

task automatic abort_run();
	$display("Some tests failed");
	$fatal(1);
endtask

task automatic check_val(string name, word_t got, word_t exp);
	if (got !== exp) begin
		$display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

// runs the image up to HALT, queues the expected stores, returns their count
function automatic int ref_run();
	word_t         rmem [MEM_WORDS];
	word_t         r [NUM_REGS];
	flags_t        f;
	word_t         pc;
	word_t         ir;
	word_t         a;
	word_t         b;
	word_t         imm;
	word_t         res;
	logic [XLEN:0] wide;
	logic [7:0]    op;
	reg_addr_t     rt;
	logic          halt;
	logic          take;
	int            nst;
	rmem = image;
	foreach (r[i])
		r[i] = '0;
	f    = '0;
	pc   = RESET_PC;
	halt = 1'b0;
	nst  = 0;
	for (int step = 0; step < 4096 && !halt; step++) begin
		ir   = rmem[pc[9:2]];
		pc   = pc + 32'd4;
		op   = ir[OPC_LSB +: OPC_W];
		rt   = ir[RT_LSB +: REG_ADDR_W];
		a    = r[ir[RA_LSB +: REG_ADDR_W]];
		b    = r[ir[RB_LSB +: REG_ADDR_W]];
		imm  = $signed(ir[IMM_LSB +: IMM_W]);
		take = 1'b0;
		if (op == OP_ADDI)
			b = imm;
		case (op)
			OP_ADD, OP_ADDI: begin
				wide = {1'b0, a} + {1'b0, b};
				res  = wide[XLEN-1:0];
				f.c  = wide[XLEN];
				f.v  = (a[XLEN-1] == b[XLEN-1]) && (res[XLEN-1] != a[XLEN-1]);
			end
			OP_SUB: begin
				res = a - b;
				f.c = (a >= b);   // no borrow
				f.v = (a[XLEN-1] != b[XLEN-1]) && (res[XLEN-1] != a[XLEN-1]);
			end
			OP_AND: res = a & b;
			OP_OR:  res = a | b;
			OP_XOR: res = a ^ b;
			OP_LD: begin
				res = a + imm;
				if (rt != '0)
					r[rt] = rmem[res[9:2]];
			end
			OP_ST: begin
				res = a + imm;
				rmem[res[9:2]] = b;
				exp_adr.push_back(res);
				exp_dat.push_back(b);
				nst++;
			end
			OP_BEQ:  take = f.z;
			OP_BNE:  take = !f.z;
			OP_BCS:  take = f.c;
			OP_BCC:  take = !f.c;
			OP_BMI:  take = f.n;
			OP_BPL:  take = !f.n;
			OP_BRA:  take = 1'b1;
			OP_HALT: halt = 1'b1;
			default: ;
		endcase
		if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI}) begin
			f.n = res[XLEN-1];
			f.z = (res == '0);
			if (rt != '0)
				r[rt] = res;
		end
		if (take)
			pc = pc + (imm << 2);
	end
	return nst;
endfunction

`endif

// ==== bench/tb_top.sv ====
module tb_top;
	import cpu_pkg::*;

	localparam int MEM_WORDS  = 256;
	localparam int DATA_BASE  = 512;    // random operands
	localparam int STORE_BASE = 768;    // one slot per store
	localparam int RUN_LIMIT  = 20000;
	localparam int WAIT_LIMIT = 200;

	logic  clk;
	logic  clk_rst;
	logic  rerun_rst = 1'b0;
	logic  rst;
	logic  cyc_o;
	logic  stb_o;
	logic  we_o;
	logic  halted_o;
	word_t adr_o;
	word_t dat_o;
	word_t dat_i = '0;
	logic  ack_i = 1'b0;
	logic  rty_i = 1'b0;

	word_t mem [MEM_WORDS];
	word_t image [MEM_WORDS];
	word_t prog_q [$];
	word_t exp_adr [$];
	word_t exp_dat [$];
	word_t lfsr_q = 32'd79;
	word_t bus_pick;
	logic  bus_noisy = 1'b0;   // wait states and retries on
	int    st_slot;
	int    n_exp;
	int    wr_seen;

	`include "tb_ref.svh"

	assign rst = clk_rst | rerun_rst;

	tb_clock #(.PERIOD(40), .RST_CYCLES(10)) u_clk (.clk_o(clk), .rst_o(clk_rst));

	cpu_top dut0 (
		.clk      (clk),
		.rst_i    (rst),
		.cyc_o    (cyc_o),
		.stb_o    (stb_o),
		.we_o     (we_o),
		.adr_o    (adr_o),
		.dat_o    (dat_o),
		.dat_i    (dat_i),
		.ack_i    (ack_i),
		.rty_i    (rty_i),
		.halted_o (halted_o)
	);

	// ------------------------------------------------------------
	// memory slave and write checker
	// ------------------------------------------------------------
	always @(posedge clk) begin
		ack_i <= 1'b0;
		rty_i <= 1'b0;
		if (stb_o && !ack_i && !rty_i) begin
			bus_pick = bus_noisy ? rand_bits(3) : 32'd7;
			if (bus_pick == 32'd2) begin
				rty_i <= 1'b1;
			end else if (bus_pick > 32'd2) begin
				ack_i <= 1'b1;
				if (we_o)
					mem[adr_o[9:2]] <= dat_o;
				else
					dat_i <= mem[adr_o[9:2]];
			end    // 0 and 1 add a wait state
		end
	end

	always @(posedge clk) begin
		if (!rst && stb_o && we_o && ack_i) begin
			wr_seen++;
			if (exp_adr.size() == 0) begin
				$display("bus write to %h at t=%0t has no expected store left", adr_o, $time);
				abort_run();
			end else begin
				check_val("adr_o", adr_o, exp_adr.pop_front());
				check_val("dat_o", dat_o, exp_dat.pop_front());
			end
		end
	end

	// ------------------------------------------------------------
	// program and run control
	// ------------------------------------------------------------
	task automatic emit(word_t w);
		prog_q.push_back(w);
	endtask

	task automatic emit_store(int rb);
		emit(enc(OP_ST, 0, 2, rb, st_slot * 4));  // r2 holds STORE_BASE
		st_slot++;
	endtask

	task automatic build_image();
		opcode_e alu_ops [5];
		opcode_e br [6];
		alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
		br      = '{OP_BCS, OP_BMI, OP_BEQ, OP_BCC, OP_BPL, OP_BNE};  // k and k+3 complement
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = {~16'(i * 4), 16'(i * 4)};
		for (int i = 0; i < 14; i++)
			image[DATA_BASE / 4 + i] = rand_bits(32);
		image[DATA_BASE / 4 + 2][31:30] = 2'b01;   // add overflows
		image[DATA_BASE / 4 + 3][31:30] = 2'b01;
		image[DATA_BASE / 4 + 4][31:30] = 2'b01;   // sub overflows
		image[DATA_BASE / 4 + 5][31:30] = 2'b10;
		st_slot = 0;
		prog_q.delete();
		emit(enc(OP_ADDI, 1, 0, 0, DATA_BASE));
		emit(enc(OP_ADDI, 2, 0, 0, STORE_BASE));
		emit(enc(OP_LD, 3, 1, 0, 0));
		emit(enc(OP_LD, 4, 1, 0, 4));
		for (int k = 0; k < 5; k++) begin
			emit(enc(alu_ops[k], 5, 3, 4, 0));
			emit_store(5);
		end
		emit(enc(OP_ADDI, 5, 3, 0, int'(rand_bits(12))));
		emit_store(5);
		// r0 as a target, then stored
		emit(enc(OP_ADD, 0, 3, 4, 0));
		emit(enc(OP_LD, 0, 1, 0, 4));
		emit_store(0);
		// each branch pair lets exactly one operand store through
		for (int k = 0; k < 6; k++) begin
			emit(enc(OP_LD, 6, 1, 0, 8 + 8 * k));
			emit(enc(OP_LD, 7, 1, 0, 12 + 8 * k));
			emit(enc(alu_ops[k % 2], 8, 6, 7, 0));
			emit_store(8);
			emit(enc(br[k], 0, 0, 0, 1));
			emit_store(6);
			emit(enc(br[(k + 3) % 6], 0, 0, 0, 1));
			emit_store(7);
		end
		emit(enc(OP_XOR, 8, 6, 6, 0));   // zero result
		emit(enc(OP_BNE, 0, 0, 0, 1));
		emit_store(6);
		emit(enc(OP_BEQ, 0, 0, 0, 1));
		emit_store(7);
		emit(enc(OP_BRA, 0, 0, 0, 1));
		emit_store(3);
		emit(enc(OP_HALT, 0, 0, 0, 0));
		emit_store(3);
		foreach (prog_q[i])
			image[i] = prog_q[i];
	endtask

	task automatic load_mem();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] <= image[i];
	endtask

	task automatic check_reset_state();
		repeat (2) @(negedge clk);
		check_val("cyc_o", cyc_o, 0);
		check_val("stb_o", stb_o, 0);
		check_val("we_o", we_o, 0);
		check_val("halted_o", halted_o, 0);
	endtask

	task automatic run_to_halt();
		int n;
		n = 0;
		while (rst && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (rst) begin
			$display("reset was not released in time");
			abort_run();
		end
		n = 0;
		while (!stb_o && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!stb_o) begin
			$display("no bus cycle started after reset");
			abort_run();
		end
		check_val("adr_o", adr_o, RESET_PC);
		check_val("we_o", we_o, 0);
		n = 0;
		while (!halted_o && n < RUN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!halted_o) begin
			$display("the core did not halt within %0d cycles", RUN_LIMIT);
			abort_run();
		end
		repeat (50) begin     // bus must stay idle
			@(negedge clk);
			check_val("cyc_o", cyc_o, 0);
			check_val("halted_o", halted_o, 1);
		end
		check_val("store count", wr_seen, n_exp);
	endtask

	initial begin
		wr_seen = 0;
		build_image();
		load_mem();
		n_exp = ref_run();
		check_reset_state();
		run_to_halt();
		// same program again on a bus with wait states and retries
		@(posedge clk);
		rerun_rst <= 1'b1;
		bus_noisy = 1'b1;
		load_mem();
		n_exp = ref_run();
		wr_seen = 0;
		repeat (3) @(posedge clk);
		check_reset_state();
		repeat (7) @(posedge clk);
		rerun_rst <= 1'b0;
		run_to_halt();
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== cpu.f ====
+incdir+bench
hw/cpu_pkg.sv
hw/mem_req_if.sv
hw/alu.sv
hw/reg_file.sv
hw/wb_master.sv
hw/cpu_control.sv
hw/cpu_top.sv
bench/tb_clock.sv
bench/tb_top.sv
